// File: hdl/cave_video_params.svh
//////////////////////////////////////////////////////////////////////
// Cave video scan-out parameters
// Timing, pixel FIFO sizing and debug overlay geometry
//////////////////////////////////////////////////////////////////////

`ifndef CAVE_VIDEO_PARAMS_SVH
`define CAVE_VIDEO_PARAMS_SVH

// Horizontal timing, in pixels
`define H_ACTIVE      320
`define H_TOTAL       384
`define H_SYNC_START  336
`define H_SYNC_END    368

// Vertical timing, in lines
`define V_ACTIVE      240
`define V_TOTAL       264
`define V_SYNC_START  244
`define V_SYNC_END    247

// Position counter width, covers both totals
`define POS_W         9

// Pixel FIFO size in 64-bit words
`define FB_FIFO_DEPTH        16
// Writer is ready while the fill count is below this
`define FB_FIFO_READY_LEVEL  14

// Four RGB555 pixels per frame-buffer word
`define PIX_PER_WORD  4

// Debug bar box in the top-left corner, two pixels per bar
`define DBG_WIDTH     64
`define DBG_HEIGHT    10

`endif

// File: hdl/cave_video_pkg.sv
//////////////////////////////////////////////////////////////////////
// Cave video types
// Pixel, word, position and control types of the scan-out path
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "cave_video_params.svh"

package cave_video_pkg;

  // One 16-bit frame-buffer pixel, top bit not displayed
  typedef struct packed {
    logic       unused;
    logic [4:0] red;
    logic [4:0] green;
    logic [4:0] blue;
  } rgb555_t;

  // Frame-buffer word, pixel 0 in the low 16 bits
  typedef rgb555_t [`PIX_PER_WORD-1:0] fb_word_t;

  // Expanded output colour
  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } rgb888_t;

  // Beam position
  typedef struct packed {
    logic [`POS_W-1:0] x;
    logic [`POS_W-1:0] y;
  } video_pos_t;

  // Sync, blanking and visible area
  typedef struct packed {
    logic hsync;
    logic vsync;
    logic hblank;
    logic vblank;
    logic enable;
  } video_ctrl_t;

  // Options from the menu
  typedef struct packed {
    logic wide;
    logic vertical;
    logic debug;
  } display_cfg_t;

  // Aspect ratio reported to the scaler
  typedef enum logic [1:0] {
    ASPECT_4_3,
    ASPECT_3_4,
    ASPECT_16_9
  } aspect_t;

endpackage

`default_nettype wire

// File: hdl/video_timing.sv
//////////////////////////////////////////////////////////////////////
// Video timing generator
// Pixel and line counters with registered sync, blanking and enable
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "cave_video_params.svh"

module video_timing
  import cave_video_pkg::*;
(
  input  logic        clk_video_i,
  input  logic        sreset_i,
  output video_pos_t  pos_o,
  output video_ctrl_t ctrl_o
);

  video_pos_t  pos_next;
  video_ctrl_t ctrl_next;

  //////////////////////////////////////////////////////////////////////
  // Next position
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    pos_next.x = pos_o.x + 1'b1;
    pos_next.y = pos_o.y;
    // End of line
    if (pos_o.x == `H_TOTAL - 1) begin
      pos_next.x = '0;
      // End of frame
      if (pos_o.y == `V_TOTAL - 1) begin
        pos_next.y = '0;
      end else begin
        pos_next.y = pos_o.y + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Window decode
  //////////////////////////////////////////////////////////////////////

  // Decoded from the next position so that the registered
  // control lines up with the registered counters
  always_comb begin
    ctrl_next.hblank = (pos_next.x >= `H_ACTIVE);
    ctrl_next.vblank = (pos_next.y >= `V_ACTIVE);
    // Active high sync pulses
    ctrl_next.hsync  = (pos_next.x >= `H_SYNC_START) &&
                       (pos_next.x <  `H_SYNC_END);
    ctrl_next.vsync  = (pos_next.y >= `V_SYNC_START) &&
                       (pos_next.y <  `V_SYNC_END);
    // Visible area only
    ctrl_next.enable = (pos_next.x < `H_ACTIVE) &&
                       (pos_next.y < `V_ACTIVE);
  end

  //////////////////////////////////////////////////////////////////////
  // Counters and control registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_video_i) begin
    if (sreset_i) begin
      pos_o  <= '0;
      // All control bits dropped in reset
      ctrl_o <= '0;
    end else begin
      pos_o  <= pos_next;
      ctrl_o <= ctrl_next;
    end
  end

endmodule

`default_nettype wire

// File: hdl/pixel_fifo.sv
//////////////////////////////////////////////////////////////////////
// Pixel FIFO
// Single clock circular buffer with fill-level ready on the write side
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "cave_video_params.svh"

module pixel_fifo
  import cave_video_pkg::*;
#(
  parameter type entry_t = fb_word_t
) (
  input  logic   clk_video_i,
  input  logic   sreset_i,
  // Write side, valid/ready
  input  entry_t wr_data_i,
  input  logic   wr_valid_i,
  output logic   wr_ready_o,
  // Read side, head entry and pop
  output entry_t rd_data_o,
  input  logic   rd_pop_i,
  output logic   empty_o
);

  localparam int ADDR_W = $clog2(`FB_FIFO_DEPTH);

  // Storage, no reset needed
  entry_t mem [`FB_FIFO_DEPTH];

  logic [ADDR_W-1:0] wr_ptr;
  logic [ADDR_W-1:0] rd_ptr;
  logic [ADDR_W:0]   count;
  logic              push;
  logic              pop;

  // Ready while below the threshold, leaves headroom for late writes
  assign wr_ready_o = (count < `FB_FIFO_READY_LEVEL);
  assign empty_o    = (count == '0);

  assign push = wr_valid_i & wr_ready_o;
  // Pop on empty is ignored
  assign pop  = rd_pop_i & ~empty_o;

  // Head of queue
  assign rd_data_o = mem[rd_ptr];

  always_ff @(posedge clk_video_i) begin
    if (push) begin
      mem[wr_ptr] <= wr_data_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Pointers and fill count
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_video_i) begin
    if (sreset_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap on the power of two depth
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/scanout_reader.sv
//////////////////////////////////////////////////////////////////////
// Scan-out reader
// Locks onto the video timing and unpacks FIFO words into pixels
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "cave_video_params.svh"

module scanout_reader
  import cave_video_pkg::*;
(
  input  logic        clk_video_i,
  input  logic        sreset_i,
  input  video_ctrl_t ctrl_i,
  // FIFO head
  input  fb_word_t    word_i,
  input  logic        empty_i,
  output logic        pop_o,
  // Current pixel
  output rgb555_t     pixel_o
);

  localparam int IDX_W = $clog2(`PIX_PER_WORD);

  logic             lock_on_video;
  logic [IDX_W-1:0] pix_idx;
  logic             consume;
  logic             last_pix;

  // One pixel per visible cycle, only once locked and with data
  assign consume  = ctrl_i.enable & lock_on_video & ~empty_i;
  assign last_pix = (pix_idx == IDX_W'(`PIX_PER_WORD - 1));

  // Word leaves the FIFO with its last pixel
  assign pop_o = consume & last_pix;

  // Black before lock and on underrun
  assign pixel_o = (lock_on_video && !empty_i) ? word_i[pix_idx] : '0;

  //////////////////////////////////////////////////////////////////////
  // Lock on video
  //////////////////////////////////////////////////////////////////////

  // First vertical blanking with data in the FIFO starts the frame
  always_ff @(posedge clk_video_i) begin
    if (sreset_i) begin
      lock_on_video <= 1'b0;
    end else if (ctrl_i.hblank && ctrl_i.vblank && !empty_i) begin
      lock_on_video <= 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Pixel index within the head word
  //////////////////////////////////////////////////////////////////////

  // Index holds on underrun so no pixel is skipped
  always_ff @(posedge clk_video_i) begin
    if (sreset_i) begin
      pix_idx <= '0;
    end else if (consume) begin
      if (last_pix) begin
        pix_idx <= '0;
      end else begin
        pix_idx <= pix_idx + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/pixel_output.sv
//////////////////////////////////////////////////////////////////////
// Pixel output stage
// RGB888 expansion, debug bar overlay, output registers, aspect ratio
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "cave_video_params.svh"

module pixel_output
  import cave_video_pkg::*;
(
  input  logic         clk_video_i,
  input  logic         sreset_i,
  input  video_pos_t   pos_i,
  input  video_ctrl_t  ctrl_i,
  input  rgb555_t      pixel_i,
  input  display_cfg_t cfg_i,
  input  logic [31:0]  debug_value_i,
  output rgb888_t      rgb_o,
  output logic         hsync_o,
  output logic         vsync_o,
  output logic         de_o,
  output logic [7:0]   arx_o,
  output logic [7:0]   ary_o
);

  // Bar number width, each bar is two pixels wide
  localparam int BAR_W = $clog2(`DBG_WIDTH) - 1;

  rgb888_t          expanded;
  rgb888_t          rgb_next;
  logic             in_box;
  logic [BAR_W-1:0] bar_idx;
  logic             bar_on;
  aspect_t          aspect;

  // Top bits repeated into the low bits
  assign expanded.red   = {pixel_i.red,   pixel_i.red[4:2]};
  assign expanded.green = {pixel_i.green, pixel_i.green[4:2]};
  assign expanded.blue  = {pixel_i.blue,  pixel_i.blue[4:2]};

  //////////////////////////////////////////////////////////////////////
  // Debug overlay
  //////////////////////////////////////////////////////////////////////

  assign in_box  = cfg_i.debug && (pos_i.x < `DBG_WIDTH) && (pos_i.y < `DBG_HEIGHT);
  assign bar_idx = pos_i.x[BAR_W:1];
  // MSB on the left
  assign bar_on  = debug_value_i[5'd31 - bar_idx];

  // White or black bar over the picture
  assign rgb_next = in_box ? {24{bar_on}} : expanded;

  // Menu priority, wide over vertical
  assign aspect = cfg_i.wide     ? ASPECT_16_9 :
                  cfg_i.vertical ? ASPECT_3_4  : ASPECT_4_3;

  //////////////////////////////////////////////////////////////////////
  // Output registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_video_i) begin
    if (sreset_i) begin
      de_o    <= 1'b0;
      hsync_o <= 1'b0;
      vsync_o <= 1'b0;
    end else begin
      de_o    <= ctrl_i.enable;
      hsync_o <= ctrl_i.hsync;
      vsync_o <= ctrl_i.vsync;
    end
  end

  // Colour and ratio follow the same cycle
  always_ff @(posedge clk_video_i) begin
    rgb_o <= rgb_next;
    case (aspect)
      ASPECT_16_9: begin
        arx_o <= 8'd16;
        ary_o <= 8'd9;
      end
      ASPECT_3_4: begin
        arx_o <= 8'd3;
        ary_o <= 8'd4;
      end
      default: begin
        arx_o <= 8'd4;
        ary_o <= 8'd3;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/cave_video_top.sv
//////////////////////////////////////////////////////////////////////
// Cave video scan-out top level
// FIFO input, lock-on-video reader and registered video output
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module cave_video_top
  import cave_video_pkg::*;
(
  input  logic         CLK_VIDEO,
  input  logic         core_sreset,
  // Frame-buffer words
  input  fb_word_t     fb_word_i,
  input  logic         fb_valid_i,
  output logic         fb_ready_o,
  // Options
  input  display_cfg_t cfg_i,
  input  logic [31:0]  debug_value_i,
  // Video out
  output rgb888_t      rgb_o,
  output logic         hsync_o,
  output logic         vsync_o,
  output logic         de_o,
  output logic [7:0]   arx_o,
  output logic [7:0]   ary_o
);

  video_pos_t  pos;
  video_ctrl_t ctrl;
  fb_word_t    head_word;
  logic        fifo_empty;
  logic        fifo_pop;
  rgb555_t     pixel;

  //////////////////////////////////////////////////////////////////////
  // Input side
  //////////////////////////////////////////////////////////////////////

  pixel_fifo #(
    .entry_t(fb_word_t)
  ) u_pixel_fifo (
    .clk_video_i(CLK_VIDEO),
    .sreset_i   (core_sreset),
    .wr_data_i  (fb_word_i),
    .wr_valid_i (fb_valid_i),
    .wr_ready_o (fb_ready_o),
    .rd_data_o  (head_word),
    .rd_pop_i   (fifo_pop),
    .empty_o    (fifo_empty)
  );

  // Timing and pixel unpacking
  video_timing u_video_timing (
    .clk_video_i(CLK_VIDEO),
    .sreset_i   (core_sreset),
    .pos_o      (pos),
    .ctrl_o     (ctrl)
  );

  scanout_reader u_scanout_reader (
    .clk_video_i(CLK_VIDEO),
    .sreset_i   (core_sreset),
    .ctrl_i     (ctrl),
    .word_i     (head_word),
    .empty_i    (fifo_empty),
    .pop_o      (fifo_pop),
    .pixel_o    (pixel)
  );

  //////////////////////////////////////////////////////////////////////
  // Output side
  //////////////////////////////////////////////////////////////////////

  pixel_output u_pixel_output (
    .clk_video_i  (CLK_VIDEO),
    .sreset_i     (core_sreset),
    .pos_i        (pos),
    .ctrl_i       (ctrl),
    .pixel_i      (pixel),
    .cfg_i        (cfg_i),
    .debug_value_i(debug_value_i),
    .rgb_o        (rgb_o),
    .hsync_o      (hsync_o),
    .vsync_o      (vsync_o),
    .de_o         (de_o),
    .arx_o        (arx_o),
    .ary_o        (ary_o)
  );

endmodule

`default_nettype wire

// File: verification/tb_cave_video.sv
//////////////////////////////////////////////////////////////////////
// Cave video scan-out testbench
// Directed tests with a pixel queue model checked on every DE cycle
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "cave_video_params.svh"

module tb_cave_video
  import cave_video_pkg::*;
;

  localparam int WAIT_LIMIT  = 250000;
  localparam int FRAME_WORDS = `H_ACTIVE * `V_ACTIVE / `PIX_PER_WORD;

  logic         CLK_VIDEO;
  logic         core_sreset;
  fb_word_t     fb_word_i;
  logic         fb_valid_i;
  logic         fb_ready_o;
  display_cfg_t cfg_i;
  logic [31:0]  debug_value_i;
  rgb888_t      rgb_o;
  logic         hsync_o;
  logic         vsync_o;
  logic         de_o;
  logic [7:0]   arx_o;
  logic [7:0]   ary_o;

  integer seed;
  int     mismatches;
  int     other_errors;
  int     cyc;

  // Pixel model, staged words wait for their FIFO write edge
  rgb555_t  pix_q[$];
  fb_word_t stage_word_q[$];
  int       stage_cyc_q[$];

  // Monitor state
  rgb888_t exp_rgb;
  rgb555_t exp_pix;
  int      de_count;
  int      frames_seen;
  int      underruns;
  int      overlay_checks;
  int      hs_len;
  int      vs_len;
  int      hs_pulses;
  int      vs_pulses;
  int      pix_x;
  int      pix_y;
  logic    vs_prev;

  cave_video_top u_cave_video_top (
    .CLK_VIDEO    (CLK_VIDEO),
    .core_sreset  (core_sreset),
    .fb_word_i    (fb_word_i),
    .fb_valid_i   (fb_valid_i),
    .fb_ready_o   (fb_ready_o),
    .cfg_i        (cfg_i),
    .debug_value_i(debug_value_i),
    .rgb_o        (rgb_o),
    .hsync_o      (hsync_o),
    .vsync_o      (vsync_o),
    .de_o         (de_o),
    .arx_o        (arx_o),
    .ary_o        (ary_o)
  );

  // 8 ns clock
  always #4 CLK_VIDEO = ~CLK_VIDEO;

  always @(posedge CLK_VIDEO) begin
    cyc <= cyc + 1;
  end

  // 5-bit channel followed by its top three bits
  function automatic rgb888_t expand_rgb555(input rgb555_t p);
    rgb888_t c;
    c.red   = {p.red,   p.red[4:2]};
    c.green = {p.green, p.green[4:2]};
    c.blue  = {p.blue,  p.blue[4:2]};
    return c;
  endfunction

  task automatic abort_run(input string msg);
    other_errors++;
    $display("ERROR at %0t: %s", $time, msg);
    $display("Errors: %0d mismatches, %0d other", mismatches, other_errors);
    $display("TEST FAILED");
    $finish;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Output monitor, sampled on the falling edge
  //////////////////////////////////////////////////////////////////////

  always @(negedge CLK_VIDEO) begin
    if (!core_sreset) begin
      // Frame boundary
      if (vsync_o && !vs_prev) begin
        // First frame after reset misses pixel 0
        if (frames_seen > 0) begin
          assert (de_count == `H_ACTIVE * `V_ACTIVE) else begin
            other_errors++;
            $display("Frame had %0d DE cycles instead of %0d", de_count,
                     `H_ACTIVE * `V_ACTIVE);
          end
        end
        frames_seen++;
        de_count = 0;
      end
      vs_prev = vsync_o;
      // Sync pulse widths
      if (hsync_o) begin
        hs_len++;
      end else if (hs_len != 0) begin
        assert (hs_len == `H_SYNC_END - `H_SYNC_START) else begin
          other_errors++;
          $display("Hsync pulse lasted %0d cycles", hs_len);
        end
        hs_pulses++;
        hs_len = 0;
      end
      if (vsync_o) begin
        vs_len++;
      end else if (vs_len != 0) begin
        assert (vs_len == (`V_SYNC_END - `V_SYNC_START) * `H_TOTAL) else begin
          other_errors++;
          $display("Vsync pulse lasted %0d cycles", vs_len);
        end
        vs_pulses++;
        vs_len = 0;
      end
      if (de_o) begin
        pix_x = de_count % `H_ACTIVE;
        pix_y = de_count / `H_ACTIVE;
        // Not locked before the first vertical blanking
        if (frames_seen == 0) begin
          exp_rgb = '0;
        end else if (pix_q.size() > 0) begin
          exp_pix = pix_q.pop_front();
          exp_rgb = expand_rgb555(exp_pix);
        end else begin
          exp_rgb = '0;
          underruns++;
        end
        // Bar overlay, MSB on the left
        if (cfg_i.debug && pix_x < `DBG_WIDTH && pix_y < `DBG_HEIGHT) begin
          exp_rgb = debug_value_i[31 - pix_x / 2] ? 24'hFFFFFF : 24'h000000;
          overlay_checks++;
        end
        assert (rgb_o == exp_rgb) else begin
          mismatches++;
          $display("MISMATCH at %0t: x=%0d y=%0d expected %06h got %06h",
                   $time, pix_x, pix_y, exp_rgb, rgb_o);
        end
        de_count++;
      end
    end
    // Words written at an earlier edge are in the FIFO by now
    while (stage_cyc_q.size() > 0 && stage_cyc_q[0] <= cyc) begin
      for (int k = 0; k < `PIX_PER_WORD; k++) begin
        pix_q.push_back(stage_word_q[0][k]);
      end
      void'(stage_word_q.pop_front());
      void'(stage_cyc_q.pop_front());
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers, called and returning on a falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic send_word(input fb_word_t word);
    int waited;
    waited = 0;
    fb_word_i  = word;
    fb_valid_i = 1'b1;
    while (!fb_ready_o) begin
      @(negedge CLK_VIDEO);
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_run("Write side stalled, fb_ready_o stayed low");
      end
    end
    // Accepted at the next rising edge
    stage_word_q.push_back(word);
    stage_cyc_q.push_back(cyc + 1);
    @(negedge CLK_VIDEO);
    fb_valid_i = 1'b0;
  endtask

  task automatic send_words(input int n);
    fb_word_t w;
    for (int i = 0; i < n; i++) begin
      for (int k = 0; k < `PIX_PER_WORD; k++) begin
        w[k] = 16'($random(seed));
      end
      send_word(w);
    end
  endtask

  task automatic wait_vsync_rise();
    int   waited;
    logic prev;
    waited = 0;
    prev   = vsync_o;
    @(negedge CLK_VIDEO);
    while (!(vsync_o && !prev)) begin
      prev = vsync_o;
      @(negedge CLK_VIDEO);
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_run("Vsync never rose");
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  // Ten reset cycles, then one cycle before DE can rise
  task automatic check_reset_state();
    for (int i = 0; i < 11; i++) begin
      if (i == 10) begin
        core_sreset = 1'b0;
      end
      @(negedge CLK_VIDEO);
      assert (!de_o && !hsync_o && !vsync_o && fb_ready_o) else begin
        other_errors++;
        $display("Outputs not idle around reset at %0t", $time);
      end
    end
  endtask

  task automatic check_back_pressure();
    int       accepted;
    fb_word_t w;
    accepted = 0;
    while (fb_ready_o) begin
      for (int k = 0; k < `PIX_PER_WORD; k++) begin
        w[k] = 16'($random(seed));
      end
      send_word(w);
      accepted++;
      if (accepted > `FB_FIFO_DEPTH) begin
        abort_run("fb_ready_o never fell while filling the FIFO");
      end
    end
    assert (accepted == `FB_FIFO_READY_LEVEL) else begin
      other_errors++;
      $display("Back-pressure after %0d words", accepted);
    end
  endtask

  task automatic check_full_frame();
    int hs0;
    int vs0;
    hs0 = hs_pulses;
    vs0 = vs_pulses;
    // Locked during the first blanking, next frame comes from the queue
    wait_vsync_rise();
    send_words(FRAME_WORDS);
    wait_vsync_rise();
    assert (hs_pulses > hs0 && vs_pulses > vs0) else begin
      other_errors++;
      $display("No sync pulses seen during the full frame");
    end
  endtask

  task automatic check_underrun();
    int u0;
    int waited;
    u0     = underruns;
    waited = 0;
    while (underruns == u0) begin
      @(negedge CLK_VIDEO);
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_run("FIFO never ran empty during visible area");
      end
    end
    // Resume, pixels continue from the queue
    send_words(1000);
    waited = 0;
    while (pix_q.size() != 0 || stage_cyc_q.size() != 0) begin
      @(negedge CLK_VIDEO);
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_run("Resumed words were never scanned out");
      end
    end
  endtask

  task automatic check_debug_overlay();
    int o0;
    wait_vsync_rise();
    o0            = overlay_checks;
    cfg_i.debug   = 1'b1;
    debug_value_i = $random(seed);
    send_words(FRAME_WORDS);
    wait_vsync_rise();
    cfg_i.debug = 1'b0;
    assert (overlay_checks - o0 == `DBG_WIDTH * `DBG_HEIGHT) else begin
      other_errors++;
      $display("Overlay box covered %0d pixels", overlay_checks - o0);
    end
  endtask

  task automatic check_aspect_ratio();
    logic [7:0] ex;
    logic [7:0] ey;
    for (int i = 0; i < 4; i++) begin
      cfg_i.wide     = i[1];
      cfg_i.vertical = i[0];
      ex = cfg_i.wide ? 8'd16 : (cfg_i.vertical ? 8'd3 : 8'd4);
      ey = cfg_i.wide ? 8'd9  : (cfg_i.vertical ? 8'd4 : 8'd3);
      @(negedge CLK_VIDEO);
      @(negedge CLK_VIDEO);
      assert (arx_o == ex && ary_o == ey) else begin
        mismatches++;
        $display("MISMATCH at %0t: aspect expected %0d:%0d got %0d:%0d",
                 $time, ex, ey, arx_o, ary_o);
      end
    end
  endtask

  initial begin
    seed           = 76;
    CLK_VIDEO      = 1'b0;
    core_sreset    = 1'b1;
    fb_word_i      = '0;
    fb_valid_i     = 1'b0;
    cfg_i          = '0;
    debug_value_i  = '0;
    cyc            = 0;
    mismatches     = 0;
    other_errors   = 0;
    de_count       = 0;
    frames_seen    = 0;
    underruns      = 0;
    overlay_checks = 0;
    hs_len         = 0;
    vs_len         = 0;
    hs_pulses      = 0;
    vs_pulses      = 0;
    vs_prev        = 1'b0;
    check_reset_state();
    check_back_pressure();
    check_full_frame();
    check_underrun();
    check_debug_overlay();
    check_aspect_ratio();
    $display("Errors: %0d mismatches, %0d other", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+hdl
hdl/cave_video_pkg.sv
hdl/video_timing.sv
hdl/pixel_fifo.sv
hdl/scanout_reader.sv
hdl/pixel_output.sv
hdl/cave_video_top.sv
verification/tb_cave_video.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the cave video testbench with Verilator

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_cave_video -f files.f -o sim_cave_video &&
./obj_dir/sim_cave_video | tee /dev/stderr | grep "TEST PASSED" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
